//--- Makefile
# Verilator simulation of the debug unit
TOP := tb_du_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- design/bp_match.sv
/*
 * Single breakpoint comparator
 *   Fetch PC or data address against the configured word
 *   Load and store qualification of memory stage accesses
 */

`timescale 1ns/10ps

module bp_match (
  input  du_map_pkg::bp_cfg_t cfg,
  input  du_cpu_pkg::cpu_obs_t obs,
  output logic                hit
);
  import du_map_pkg::*;
  import du_cpu_pkg::*;

  logic mem_ok;
  logic mem_read;
  logic mem_write;
  logic pc_eq;
  logic adr_eq;

  // Memory stage carries a valid access
  assign mem_ok    = ~|obs.mem_exception & ~obs.mem_bubble;
  assign mem_read  = mem_ok & (obs.mem_instr[6:2] == OPC_LOAD);
  assign mem_write = mem_ok & (obs.mem_instr[6:2] == OPC_STORE);

  // Address compares
  assign pc_eq  = (obs.if_pc == cfg.data);
  assign adr_eq = (obs.mem_memadr == cfg.data);

  ////////////////////
  always_comb begin
    hit = 1'b0;
    if (cfg.enabled) begin
      case (cfg.cc)
        // Fetched instruction not being thrown away
        CC_FETCH:    hit = pc_eq & ~obs.bu_flush & ~obs.st_flush;
        CC_LD_ADR:   hit = adr_eq & obs.dmem_ack & mem_read;
        CC_ST_ADR:   hit = adr_eq & obs.dmem_ack & mem_write;
        CC_LDST_ADR: hit = adr_eq & obs.dmem_ack & (mem_read | mem_write);
        // Reserved codes never fire
        default:     hit = 1'b0;
      endcase
    end
  end

endmodule

//--- design/du_cpu_pkg.sv
/*
 * CPU side of the debug unit
 *   Major opcode encodings used by the breakpoint logic
 *   Observation struct of fetch and memory stage signals
 */

package du_cpu_pkg;

  // Instruction bits 6 to 2
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_STORE  = 5'b01000,
    OPC_BRANCH = 5'b11000
  } opcode_e;

  ////////////////////
  // Pipeline state seen by the debug unit
  typedef struct packed {
    // Fetch stage
    logic [du_map_pkg::DU_XLEN-1:0] if_pc;
    logic [31:0]                    if_instr;
    logic                           if_bubble;
    // Memory stage
    logic [31:0]                    mem_instr;
    logic                           mem_bubble;
    logic [15:0]                    mem_exception;
    logic [du_map_pkg::DU_XLEN-1:0] mem_memadr;
    logic                           dmem_ack;
    // Pipeline flushes
    logic                           bu_flush;
    logic                           st_flush;
  } cpu_obs_t;

endpackage

//--- design/du_halt_ctrl.sv
/*
 * Halt control of the debug unit
 *   Instruction and branch break detection
 *   Sticky hit register, breakpoint output, stall and flush
 */

`timescale 1ns/10ps

module du_halt_ctrl #(
  parameter int BREAKPOINTS = 3
) (
  input  logic                                   clk,
  input  logic                                   rstn,
  input  du_map_pkg::du_wr_t                     wr,
  input  du_cpu_pkg::cpu_obs_t                   obs,
  input  logic [du_map_pkg::MAX_BREAKPOINTS-1:0] bp_hit,
  input  logic                                   instr_break_ena,
  input  logic                                   branch_break_ena,
  input  logic                                   dbg_stall,
  input  logic                                   ex_stall,
  input  logic [31:0]                            du_exceptions,
  output logic [9:0]                             hit_bits,
  output logic                                   dbg_bp,
  output logic                                   du_stall,
  output logic                                   du_stall_dly,
  output logic                                   du_flush
);
  import du_map_pkg::*;
  import du_cpu_pkg::*;

  logic                       instr_hit;
  logic                       branch_hit;
  logic                       hit_wr;
  logic                       instr_sticky;
  logic                       branch_sticky;
  logic [MAX_BREAKPOINTS-1:0] bp_sticky;

  // Break on every valid fetch, or on fetched branches only
  assign instr_hit  = instr_break_ena & ~obs.if_bubble;
  assign branch_hit = branch_break_ena & ~obs.if_bubble & (obs.if_instr[6:2] == OPC_BRANCH);
  assign hit_wr     = wr.we & (wr.addr == DBG_HIT);

  ////////////////////
  // Sticky hits, a debugger write replaces them
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instr_sticky  <= 1'b0;
      branch_sticky <= 1'b0;
    end else if (hit_wr) begin
      instr_sticky  <= wr.data[0];
      branch_sticky <= wr.data[1];
    end else begin
      if (instr_hit) instr_sticky <= 1'b1;
      if (branch_hit) branch_sticky <= 1'b1;
    end
  end

  for (genvar n = 0; n < MAX_BREAKPOINTS; n++) begin : gen_sticky
    if (n < BREAKPOINTS) begin : gen_impl
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) bp_sticky[n] <= 1'b0;
        else if (hit_wr) bp_sticky[n] <= wr.data[n+4];
        else if (bp_hit[n]) bp_sticky[n] <= 1'b1;
      end
    end else begin : gen_absent
      assign bp_sticky[n] = 1'b0;
    end
  end

  assign hit_bits = {bp_sticky, branch_sticky, instr_sticky};

  ////////////////////
  // Stall straight from the debugger, flush when it lets go
  assign du_stall = dbg_stall;
  assign du_flush = du_stall_dly & ~dbg_stall & |du_exceptions;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      du_stall_dly <= 1'b0;
      dbg_bp       <= 1'b0;
    end else begin
      du_stall_dly <= du_stall;
      // Hold off while the pipeline is stalled or flushing
      dbg_bp <= ~ex_stall & ~du_stall & ~du_flush & ~obs.bu_flush & ~obs.st_flush &
                (|du_exceptions | |hit_bits);
    end
  end

  // Flush only on the falling edge of the stall
  a_flush_on_release : assert property (@(posedge clk) disable iff (!rstn)
    du_flush |-> !dbg_stall && $past(dbg_stall));

endmodule

//--- design/du_map_pkg.sv
/*
 * Debug unit register map
 *   Data, offset and address widths, breakpoint limit
 *   Bank field and register offset encodings
 *   Breakpoint condition codes
 *   Write bus and breakpoint configuration structs
 */

package du_map_pkg;

  // Widths of the debug port
  parameter int DU_XLEN         = 64;
  parameter int DU_ADDR_SIZE    = 12;
  parameter int DU_PLEN         = 64;
  parameter int MAX_BREAKPOINTS = 8;

  // Bank field, address bits above the register offset
  // Only the internal bank is decoded here
  typedef enum logic [DU_PLEN-DU_ADDR_SIZE-1:0] {
    DBG_INTERNAL = 'h0,
    DBG_GPRS     = 'h1,
    DBG_CSRS     = 'h2
  } du_bank_e;

  ////////////////////
  // Internal bank offsets
  typedef enum logic [DU_ADDR_SIZE-1:0] {
    DBG_CTRL    = 12'h000,
    DBG_HIT     = 12'h001,
    DBG_IE      = 12'h002,
    DBG_CAUSE   = 12'h003,
    DBG_BPCTRL0 = 12'h010,
    DBG_BPDATA0 = 12'h011,
    DBG_BPCTRL1 = 12'h012,
    DBG_BPDATA1 = 12'h013,
    DBG_BPCTRL2 = 12'h014,
    DBG_BPDATA2 = 12'h015,
    DBG_BPCTRL3 = 12'h016,
    DBG_BPDATA3 = 12'h017,
    DBG_BPCTRL4 = 12'h018,
    DBG_BPDATA4 = 12'h019,
    DBG_BPCTRL5 = 12'h01a,
    DBG_BPDATA5 = 12'h01b,
    DBG_BPCTRL6 = 12'h01c,
    DBG_BPDATA6 = 12'h01d,
    DBG_BPCTRL7 = 12'h01e,
    DBG_BPDATA7 = 12'h01f
  } du_reg_e;

  // Breakpoint condition, what the data word is compared to
  typedef enum logic [2:0] {
    CC_FETCH    = 3'd0,
    CC_LD_ADR   = 3'd1,
    CC_ST_ADR   = 3'd2,
    CC_LDST_ADR = 3'd3
  } bp_cc_e;

  ////////////////////
  // Registered write bus towards the internal bank
  typedef struct packed {
    logic                    we;
    logic [DU_ADDR_SIZE-1:0] addr;
    logic [DU_XLEN-1:0]      data;
  } du_wr_t;

  // One breakpoint setting
  typedef struct packed {
    logic               enabled;
    bp_cc_e             cc;
    logic [DU_XLEN-1:0] data;
  } bp_cfg_t;

endpackage

//--- design/du_port.sv
/*
 * Debugger port of the debug unit
 *   Strobe edge detection and bank decode
 *   Registered write bus, acknowledge shifter, read data register
 */

`timescale 1ns/10ps

module du_port (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           dbg_strb,
  input  logic                           dbg_we,
  input  logic                           dbg_stall,
  input  logic                           ex_stall,
  input  logic [du_map_pkg::DU_PLEN-1:0] dbg_addr,
  input  logic [du_map_pkg::DU_XLEN-1:0] dbg_dati,
  input  logic [du_map_pkg::DU_XLEN-1:0] rdata,
  output du_map_pkg::du_wr_t             wr,
  output logic [du_map_pkg::DU_XLEN-1:0] dbg_dato,
  output logic                           dbg_ack
);
  import du_map_pkg::*;

  du_bank_e                bank;
  logic                    sel_internal;
  logic                    strb_dly;
  logic                    access;
  logic                    first_we;
  logic [2:0]              ack_sr;
  logic                    wr_we;
  logic [DU_ADDR_SIZE-1:0] wr_addr;
  logic [DU_XLEN-1:0]      wr_data;

  ////////////////////
  // Address decode
  assign bank         = du_bank_e'(dbg_addr[DU_PLEN-1:DU_ADDR_SIZE]);
  assign sel_internal = (bank == DBG_INTERNAL);

  // Other banks only answer while the CPU is stalled
  assign access   = dbg_strb & (dbg_stall | sel_internal);
  // First strobe cycle of a write
  assign first_we = access & ~strb_dly & dbg_we;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      strb_dly <= 1'b0;
      wr_we    <= 1'b0;
    end else begin
      strb_dly <= dbg_strb;
      wr_we    <= first_we & sel_internal;
    end
  end

  // Offset and data follow the port every cycle
  always_ff @(posedge clk) begin
    wr_addr <= dbg_addr[DU_ADDR_SIZE-1:0];
    wr_data <= dbg_dati;
  end

  assign wr = '{we: wr_we, addr: wr_addr, data: wr_data};

  ////////////////////
  // Ack shifter, fills from the top while the access lasts
  // Frozen while the execute stage stalls
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ack_sr <= 3'b000;
    end else if (!ex_stall) begin
      ack_sr <= {3{access & ~dbg_ack}} & {1'b1, ack_sr[2:1]};
    end
  end

  assign dbg_ack = ack_sr[0];

  // Read data, zero outside the internal bank
  always_ff @(posedge clk) begin
    dbg_dato <= sel_internal ? rdata : '0;
  end

  // Ack is a single pulse, the debugger has to drop the strobe
  a_ack_pulse : assert property (@(posedge clk) disable iff (!rstn)
    dbg_ack |=> !dbg_ack);

endmodule

//--- design/du_regs.sv
/*
 * Register bank of the debug unit
 *   Break enables, interrupt enable and cause registers
 *   Breakpoint control and data pairs
 *   Internal read multiplexer
 */

`timescale 1ns/10ps

module du_regs #(
  parameter int BREAKPOINTS = 3
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  du_map_pkg::du_wr_t             wr,
  input  logic [31:0]                    du_exceptions,
  input  logic [9:0]                     hit_bits,
  output logic                           instr_break_ena,
  output logic                           branch_break_ena,
  output du_map_pkg::bp_cfg_t            cfg [du_map_pkg::MAX_BREAKPOINTS],
  output logic [31:0]                    du_ie,
  output logic [du_map_pkg::DU_XLEN-1:0] rdata
);
  import du_map_pkg::*;

  logic [31:0]                ie;
  logic [DU_XLEN-1:0]         cause;
  logic [3:0]                 trap_idx;
  logic [3:0]                 irq_idx;
  logic [MAX_BREAKPOINTS-1:0] implemented;
  logic [MAX_BREAKPOINTS-1:0] en_mask;

  ////////////////////
  // Control and interrupt enable
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instr_break_ena  <= 1'b0;
      branch_break_ena <= 1'b0;
      ie               <= '0;
    end else if (wr.we) begin
      if (wr.addr == DBG_CTRL) begin
        instr_break_ena  <= wr.data[0];
        branch_break_ena <= wr.data[1];
      end
      if (wr.addr == DBG_IE) ie <= wr.data[31:0];
    end
  end

  assign du_ie = ie;

  // Lowest pending trap and interrupt
  always_comb begin
    trap_idx = '0;
    irq_idx  = '0;
    for (int i = 15; i >= 0; i--) begin
      if (du_exceptions[i]) trap_idx = 4'(i);
      if (du_exceptions[i+16]) irq_idx = 4'(i);
    end
  end

  // Cause, debugger write first, then traps, then interrupts
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cause <= '0;
    end else if (wr.we && wr.addr == DBG_CAUSE) begin
      cause <= wr.data;
    end else if (|du_exceptions[15:0]) begin
      cause <= DU_XLEN'(trap_idx);
    end else if (|du_exceptions[31:16]) begin
      cause <= {1'b1, (DU_XLEN-1)'(irq_idx)};
    end
  end

  ////////////////////
  // Breakpoint pairs, only the first BREAKPOINTS exist
  for (genvar n = 0; n < MAX_BREAKPOINTS; n++) begin : gen_bp
    if (n < BREAKPOINTS) begin : gen_impl
      logic               en_q;
      bp_cc_e             cc_q;
      logic [DU_XLEN-1:0] data_q;

      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          en_q   <= 1'b0;
          cc_q   <= CC_FETCH;
          data_q <= '0;
        end else if (wr.we) begin
          if (wr.addr == DU_ADDR_SIZE'(DBG_BPCTRL0 + 2 * n)) begin
            en_q <= wr.data[1];
            cc_q <= bp_cc_e'(wr.data[6:4]);
          end
          if (wr.addr == DU_ADDR_SIZE'(DBG_BPDATA0 + 2 * n)) data_q <= wr.data;
        end
      end

      assign cfg[n]         = '{enabled: en_q, cc: cc_q, data: data_q};
      assign implemented[n] = 1'b1;
    end else begin : gen_absent
      assign cfg[n]         = '0;
      assign implemented[n] = 1'b0;
    end
    assign en_mask[n] = cfg[n].enabled;
  end

  ////////////////////
  // Read mux on the registered offset
  always_comb begin
    rdata = '0;
    case (wr.addr)
      DBG_CTRL:  rdata[1:0]  = {branch_break_ena, instr_break_ena};
      DBG_HIT:   rdata[11:0] = {hit_bits[9:2], 2'b00, hit_bits[1:0]};
      DBG_IE:    rdata[31:0] = ie;
      DBG_CAUSE: rdata       = cause;
      default: begin
        for (int n = 0; n < MAX_BREAKPOINTS; n++) begin
          if (wr.addr == DU_ADDR_SIZE'(DBG_BPCTRL0 + 2 * n))
            rdata[6:0] = {cfg[n].cc, 2'b00, cfg[n].enabled, implemented[n]};
          if (wr.addr == DU_ADDR_SIZE'(DBG_BPDATA0 + 2 * n))
            rdata = cfg[n].data;
        end
      end
    endcase
  end

  // Missing breakpoints stay disabled whatever the debugger writes
  a_no_ghost_bp : assert property (@(posedge clk) disable iff (!rstn)
    (en_mask & ~implemented) == '0);

endmodule

//--- design/du_top.sv
/*
 * Debug unit top level
 *   Debugger port, register bank, halt control
 *   Array of breakpoint comparators
 */

`timescale 1ns/10ps

module du_top #(
  parameter int BREAKPOINTS = 3
) (
  input  logic                           clk,
  input  logic                           rstn,
  // Debugger side
  input  logic                           dbg_stall,
  input  logic                           dbg_strb,
  input  logic                           dbg_we,
  input  logic [du_map_pkg::DU_PLEN-1:0] dbg_addr,
  input  logic [du_map_pkg::DU_XLEN-1:0] dbg_dati,
  output logic [du_map_pkg::DU_XLEN-1:0] dbg_dato,
  output logic                           dbg_ack,
  output logic                           dbg_bp,
  // CPU side
  output logic                           du_stall,
  output logic                           du_stall_dly,
  output logic                           du_flush,
  output logic [31:0]                    du_ie,
  input  du_cpu_pkg::cpu_obs_t           obs,
  input  logic                           ex_stall,
  input  logic [31:0]                    du_exceptions
);
  import du_map_pkg::*;

  du_wr_t                     wr;
  logic [DU_XLEN-1:0]         rdata;
  logic [9:0]                 hit_bits;
  logic                       instr_break_ena;
  logic                       branch_break_ena;
  bp_cfg_t                    cfg [MAX_BREAKPOINTS];
  logic [MAX_BREAKPOINTS-1:0] bp_hit;

  du_port u_port (
    .clk, .rstn, .dbg_strb, .dbg_we, .dbg_stall, .ex_stall,
    .dbg_addr, .dbg_dati, .rdata, .wr, .dbg_dato, .dbg_ack
  );

  du_regs #(.BREAKPOINTS(BREAKPOINTS)) u_regs (
    .clk, .rstn, .wr, .du_exceptions, .hit_bits,
    .instr_break_ena, .branch_break_ena, .cfg, .du_ie, .rdata
  );

  ////////////////////
  // One comparator per implemented breakpoint
  for (genvar n = 0; n < MAX_BREAKPOINTS; n++) begin : gen_match
    if (n < BREAKPOINTS) begin : gen_impl
      bp_match u_match (
        .cfg (cfg[n]),
        .obs (obs),
        .hit (bp_hit[n])
      );
    end else begin : gen_absent
      assign bp_hit[n] = 1'b0;
    end
  end

  du_halt_ctrl #(.BREAKPOINTS(BREAKPOINTS)) u_halt (
    .clk, .rstn, .wr, .obs, .bp_hit, .instr_break_ena, .branch_break_ena,
    .dbg_stall, .ex_stall, .du_exceptions, .hit_bits,
    .dbg_bp, .du_stall, .du_stall_dly, .du_flush
  );

endmodule

//--- filelist.f
+incdir+tests
design/du_map_pkg.sv
design/du_cpu_pkg.sv
design/du_port.sv
design/du_regs.sv
design/bp_match.sv
design/du_halt_ctrl.sv
design/du_top.sv
tests/tb_du_top.sv

//--- tests/tb_du_ref.svh
/*
 * Reference model of the debug unit for the testbench
 *   Fibonacci LFSR step
 *   Cause encoding of traps and interrupts
 *   Readback layouts of breakpoint control and hit registers
 *   Breakpoint and break enable hit rules
 */

`ifndef TB_DU_REF_SVH
`define TB_DU_REF_SVH

// Taps 32 22 2 1, new bit enters at the bottom
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// Lowest trap wins, else lowest interrupt with the top bit set
function automatic logic [63:0] ref_cause(input logic [31:0] exc, input logic [63:0] prev);
  for (int i = 0; i < 16; i++) begin
    if (exc[i]) return 64'(i);
  end
  for (int i = 16; i < 32; i++) begin
    if (exc[i]) return {1'b1, 63'(i - 16)};
  end
  // Nothing pending, register keeps its value
  return prev;
endfunction

// Implemented bit 0, enabled bit 1, cc in 6..4
function automatic logic [63:0] ref_bpctrl(input logic impl, input logic [63:0] wdata);
  if (!impl) return 64'd0;
  return {57'd0, wdata[6:4], 2'b00, wdata[1], 1'b1};
endfunction

// Instruction hit bit 0, branch hit bit 1, breakpoints from bit 4
function automatic logic [63:0] ref_hit(input logic [1:0] brk, input logic [7:0] bp);
  return {52'd0, bp, 2'b00, brk};
endfunction

// Hit rule of one enabled breakpoint
function automatic logic ref_bp_hit(input logic [2:0] cc, input logic [63:0] data,
                                    input cpu_obs_t o);
  logic valid;
  logic is_ld;
  logic is_st;
  valid = (o.mem_exception == 16'h0) && !o.mem_bubble;
  is_ld = valid && (o.mem_instr[6:2] == 5'b00000);
  is_st = valid && (o.mem_instr[6:2] == 5'b01000);
  if (cc == 3'd0) return (o.if_pc == data) && !o.bu_flush && !o.st_flush;
  // All memory conditions need the address and a data ack
  if (o.mem_memadr != data || !o.dmem_ack) return 1'b0;
  if (cc == 3'd1) return is_ld;
  if (cc == 3'd2) return is_st;
  if (cc == 3'd3) return is_ld || is_st;
  return 1'b0;
endfunction

// Returns {branch hit, instruction hit}
function automatic logic [1:0] ref_break_hits(input logic instr_en, input logic branch_en,
                                              input cpu_obs_t o);
  logic fetch_ok;
  fetch_ok = !o.if_bubble;
  return {branch_en && fetch_ok && (o.if_instr[6:2] == 5'b11000), instr_en && fetch_ok};
endfunction

`endif

//--- tests/tb_du_top.sv
/*
 * Testbench of the debug unit
 *   Clock, reset and LFSR stimulus
 *   Debugger bus tasks with ack timeout
 *   Register, cause, breakpoint, break enable, stall and flush tests
 *   Comparing process fed by a queue of expected values
 */

`timescale 1ns/10ps

module tb_du_top;
  import du_map_pkg::*;
  import du_cpu_pkg::*;

  `include "tb_du_ref.svh"

  localparam int          ACK_LATENCY = 3;
  localparam int          ACK_TIMEOUT = 40;
  localparam logic [31:0] INSTR_ADDI  = 32'h0000_0013;
  localparam logic [31:0] INSTR_BEQ   = 32'h0000_0063;
  localparam logic [31:0] INSTR_LD    = 32'h0000_3003;
  localparam logic [31:0] INSTR_SD    = 32'h0000_3023;
  localparam logic [63:0] IDLE_PC     = 64'h0000_0000_8000_0000;
  localparam logic [63:0] IDLE_ADR    = 64'h0000_0000_4000_0000;

  logic        clk = 1'b0;
  logic        rstn;
  logic        dbg_stall;
  logic        dbg_strb;
  logic        dbg_we;
  logic [63:0] dbg_addr;
  logic [63:0] dbg_dati;
  logic [63:0] dbg_dato;
  logic        dbg_ack;
  logic        dbg_bp;
  logic        du_stall;
  logic        du_stall_dly;
  logic        du_flush;
  logic [31:0] du_ie;
  cpu_obs_t    obs;
  logic        ex_stall;
  logic [31:0] du_exceptions;

  logic [31:0] lfsr_state = 32'h3939b780;
  int          err_count  = 0;
  int          chk_count  = 0;
  string       name_q[$];
  logic [63:0] got_q[$];
  logic [63:0] exp_q[$];

  du_top #(.BREAKPOINTS(3)) i_dut (
    .clk, .rstn, .dbg_stall, .dbg_strb, .dbg_we, .dbg_addr, .dbg_dati,
    .dbg_dato, .dbg_ack, .dbg_bp, .du_stall, .du_stall_dly, .du_flush,
    .du_ie, .obs, .ex_stall, .du_exceptions
  );

  always #20 clk = ~clk;

  ////////////////////
  // Helpers
  function automatic logic [63:0] rand_word(input int nbits);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [63:0] bp_ctrl_addr(input int n);
    return 64'(DBG_BPCTRL0) + 64'(2 * n);
  endfunction

  function automatic logic [63:0] bp_data_addr(input int n);
    return 64'(DBG_BPDATA0) + 64'(2 * n);
  endfunction

  // Quiet pipeline with bubbles in every stage
  function automatic cpu_obs_t idle_obs();
    cpu_obs_t o;
    o            = '0;
    o.if_pc      = IDLE_PC;
    o.if_instr   = INSTR_ADDI;
    o.if_bubble  = 1'b1;
    o.mem_instr  = INSTR_ADDI;
    o.mem_bubble = 1'b1;
    o.mem_memadr = IDLE_ADR;
    return o;
  endfunction

  function automatic cpu_obs_t fetch_obs(input logic [63:0] pc, input logic [31:0] instr,
                                         input logic bubble, input logic flush);
    cpu_obs_t o;
    o           = idle_obs();
    o.if_pc     = pc;
    o.if_instr  = instr;
    o.if_bubble = bubble;
    o.bu_flush  = flush;
    return o;
  endfunction

  function automatic cpu_obs_t mem_obs(input logic [63:0] adr, input logic store,
                                       input logic ack);
    cpu_obs_t o;
    o            = idle_obs();
    o.mem_instr  = store ? INSTR_SD : INSTR_LD;
    o.mem_bubble = 1'b0;
    o.mem_memadr = adr;
    o.dmem_ack   = ack;
    return o;
  endfunction

  // Queue a value for the comparing process
  function automatic void expect_val(input string name, input logic [63:0] got,
                                     input logic [63:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endfunction

  task report_failure();
    err_count++;
    $display("Testbench failed");
    $fatal(1, "Stopped at the first error");
  endtask

  ////////////////////
  // Debugger bus access that holds the strobe until ack and returns at a falling edge
  task automatic bus_access(input logic we, input logic [63:0] addr, input logic [63:0] wdata,
                            output logic [63:0] rdata, output int latency);
    @(posedge clk);
    dbg_strb <= 1'b1;
    dbg_we   <= we;
    dbg_addr <= addr;
    dbg_dati <= wdata;
    latency = 0;
    @(negedge clk);
    while (!dbg_ack) begin
      if (latency >= ACK_TIMEOUT) begin
        $display("Timed out waiting for dbg_ack at address %h", addr);
        report_failure();
      end
      @(negedge clk);
      latency++;
    end
    rdata = dbg_dato;
    // Strobe low for at least one cycle before the next access
    @(posedge clk);
    dbg_strb <= 1'b0;
    dbg_we   <= 1'b0;
    @(negedge clk);
  endtask

  task automatic bus_write(input logic [63:0] addr, input logic [63:0] data);
    logic [63:0] rd;
    int          lat;
    bus_access(1'b1, addr, data, rd, lat);
  endtask

  task automatic bus_read(input logic [63:0] addr, output logic [63:0] data);
    int lat;
    bus_access(1'b0, addr, 64'd0, data, lat);
  endtask

  task automatic read_expect(input logic [63:0] addr, input logic [63:0] exp);
    logic [63:0] rd;
    bus_read(addr, rd);
    expect_val($sformatf("dbg_dato at %h", addr), rd, exp);
  endtask

  // One cycle of pipeline activity
  task automatic apply_pulse(input cpu_obs_t p);
    @(posedge clk);
    obs <= p;
    @(posedge clk);
    obs <= idle_obs();
    @(negedge clk);
  endtask

  ////////////////////
  // Breakpoint n with condition cc against one access of the given kind
  task automatic bp_case(input int n, input bp_cc_e cc, input int kind);
    logic [63:0] adr;
    cpu_obs_t    pulse;
    logic        exp_hit;
    adr = rand_word(64);
    case (kind)
      0:       pulse = fetch_obs(adr, INSTR_ADDI, 1'b0, 1'b0);
      1:       pulse = fetch_obs(adr, INSTR_ADDI, 1'b0, 1'b1);
      2:       pulse = mem_obs(adr, 1'b0, 1'b1);
      3:       pulse = mem_obs(adr, 1'b1, 1'b1);
      default: pulse = mem_obs(adr, 1'b1, 1'b0);
    endcase
    exp_hit = ref_bp_hit(cc, adr, pulse);
    bus_write(bp_data_addr(n), adr);
    bus_write(bp_ctrl_addr(n), {57'd0, cc, 4'b0010});
    bus_write(64'(DBG_HIT), 64'd0);
    apply_pulse(pulse);
    read_expect(64'(DBG_HIT), ref_hit(2'b00, 8'(exp_hit) << n));
    expect_val("dbg_bp", 64'(dbg_bp), 64'(exp_hit));
    // Disable and clear the sticky bit
    bus_write(bp_ctrl_addr(n), 64'd0);
    bus_write(64'(DBG_HIT), 64'd0);
    read_expect(64'(DBG_HIT), 64'd0);
    expect_val("dbg_bp", 64'(dbg_bp), 64'd0);
  endtask

  task automatic break_case(input logic [1:0] ctrl, input cpu_obs_t pulse);
    logic [1:0] brk;
    brk = ref_break_hits(ctrl[0], ctrl[1], pulse);
    bus_write(64'(DBG_CTRL), 64'(ctrl));
    bus_write(64'(DBG_HIT), 64'd0);
    apply_pulse(pulse);
    read_expect(64'(DBG_HIT), ref_hit(brk, 8'd0));
    expect_val("dbg_bp", 64'(dbg_bp), 64'(|brk));
    bus_write(64'(DBG_CTRL), 64'd0);
    bus_write(64'(DBG_HIT), 64'd0);
  endtask

  // Stall for one cycle and release it with exc pending
  task automatic stall_release(input logic [31:0] exc);
    @(posedge clk);
    dbg_stall     <= 1'b1;
    du_exceptions <= exc;
    @(negedge clk);
    expect_val("du_stall", 64'(du_stall), 64'd1);
    expect_val("du_stall_dly", 64'(du_stall_dly), 64'd0);
    @(posedge clk);
    dbg_stall <= 1'b0;
    @(negedge clk);
    expect_val("du_stall", 64'(du_stall), 64'd0);
    expect_val("du_stall_dly", 64'(du_stall_dly), 64'd1);
    expect_val("du_flush", 64'(du_flush), 64'(exc != 32'd0));
    @(negedge clk);
    expect_val("du_stall_dly", 64'(du_stall_dly), 64'd0);
    expect_val("du_flush", 64'(du_flush), 64'd0);
    @(posedge clk);
    du_exceptions <= 32'd0;
    @(negedge clk);
  endtask

  ////////////////////
  // Comparing process
  always @(negedge clk) begin : compare
    string       name;
    logic [63:0] got;
    logic [63:0] exp;
    while (name_q.size() > 0) begin
      name = name_q.pop_front();
      got  = got_q.pop_front();
      exp  = exp_q.pop_front();
      chk_count++;
      assert (got === exp) else begin
        $display("Error: %s is %h, expected %h", name, got, exp);
        report_failure();
      end
    end
  end

  ////////////////////
  // Stimulus
  initial begin : stimulus
    logic [63:0] rd;
    logic [63:0] v;
    logic [63:0] prev;
    logic [31:0] exc;
    int          lat;
    int          drain;
    rstn          = 1'b0;
    dbg_stall     = 1'b0;
    dbg_strb      = 1'b0;
    dbg_we        = 1'b0;
    dbg_addr      = 64'd0;
    dbg_dati      = 64'd0;
    obs           = idle_obs();
    ex_stall      = 1'b0;
    du_exceptions = 32'd0;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;

    // Reset values and ack latency
    bus_access(1'b0, 64'(DBG_CTRL), 64'd0, rd, lat);
    assert (lat == ACK_LATENCY) else begin
      $display("dbg_ack did not arrive %0d cycles after the strobe", ACK_LATENCY);
      report_failure();
    end
    expect_val("dbg_dato at DBG_CTRL", rd, 64'd0);
    for (int a = 0; a < 4; a++) read_expect(64'(a), 64'd0);
    // Implemented breakpoints still show their implemented bit
    for (int n = 0; n < MAX_BREAKPOINTS; n++) begin
      read_expect(bp_ctrl_addr(n), ref_bpctrl(n < 3, 64'd0));
      read_expect(bp_data_addr(n), 64'd0);
    end
    // Other bank answers zero while stalled
    bus_write(64'(DBG_CTRL), 64'd3);
    @(posedge clk);
    dbg_stall <= 1'b1;
    read_expect(64'h1000, 64'd0);
    @(posedge clk);
    dbg_stall <= 1'b0;
    bus_write(64'(DBG_CTRL), 64'd0);

    // Random readback through the layouts
    repeat (3) begin
      v = rand_word(64);
      bus_write(64'(DBG_CTRL), v);
      read_expect(64'(DBG_CTRL), v & 64'd3);
      v = rand_word(64);
      bus_write(64'(DBG_IE), v);
      read_expect(64'(DBG_IE), {32'd0, v[31:0]});
      expect_val("du_ie", 64'(du_ie), {32'd0, v[31:0]});
      for (int n = 0; n < MAX_BREAKPOINTS; n++) begin
        v = rand_word(64);
        bus_write(bp_data_addr(n), v);
        read_expect(bp_data_addr(n), (n < 3) ? v : 64'd0);
        v = rand_word(64);
        bus_write(bp_ctrl_addr(n), v);
        read_expect(bp_ctrl_addr(n), ref_bpctrl(n < 3, v));
      end
    end
    for (int n = 0; n < 3; n++) bus_write(bp_ctrl_addr(n), 64'd0);
    bus_write(64'(DBG_CTRL), 64'd0);
    bus_write(64'(DBG_HIT), 64'd0);
    read_expect(64'(DBG_HIT), 64'd0);

    // Cause register after a debugger write and under sparse exceptions
    prev = rand_word(64);
    bus_write(64'(DBG_CAUSE), prev);
    read_expect(64'(DBG_CAUSE), prev);
    repeat (12) begin
      exc = 32'(rand_word(32)) & 32'(rand_word(32)) & 32'(rand_word(32));
      if (rand_word(1) == 64'd1) exc[15:0] = 16'h0;
      @(posedge clk);
      du_exceptions <= exc;
      prev = ref_cause(exc, prev);
      read_expect(64'(DBG_CAUSE), prev);
      expect_val("dbg_bp", 64'(dbg_bp), 64'(exc != 32'd0));
    end
    @(posedge clk);
    du_exceptions <= 32'd0;

    // Breakpoint hits and misses for each condition
    bp_case(0, CC_FETCH, 0);
    bp_case(1, CC_LD_ADR, 2);
    bp_case(2, CC_ST_ADR, 3);
    bp_case(0, CC_LDST_ADR, 3);
    bp_case(1, CC_LDST_ADR, 2);
    bp_case(2, CC_LD_ADR, 3);
    bp_case(0, CC_FETCH, 1);
    bp_case(1, CC_ST_ADR, 4);

    // Instruction and branch break enables
    break_case(2'b01, fetch_obs(IDLE_PC, INSTR_ADDI, 1'b1, 1'b0));
    break_case(2'b01, fetch_obs(IDLE_PC, INSTR_ADDI, 1'b0, 1'b0));
    break_case(2'b10, fetch_obs(IDLE_PC, INSTR_ADDI, 1'b0, 1'b0));
    break_case(2'b10, fetch_obs(IDLE_PC, INSTR_BEQ, 1'b1, 1'b0));
    break_case(2'b10, fetch_obs(IDLE_PC, INSTR_BEQ, 1'b0, 1'b0));
    break_case(2'b11, fetch_obs(IDLE_PC, INSTR_BEQ, 1'b0, 1'b0));

    // Ack withheld while the execute stage stalls
    v = {32'd0, 32'(rand_word(32))};
    bus_write(64'(DBG_IE), v);
    @(posedge clk);
    ex_stall <= 1'b1;
    fork
      bus_access(1'b0, 64'(DBG_IE), 64'd0, rd, lat);
      begin
        repeat (6) begin
          @(negedge clk);
          expect_val("dbg_ack", 64'(dbg_ack), 64'd0);
        end
        @(posedge clk);
        ex_stall <= 1'b0;
      end
    join
    expect_val("dbg_dato at DBG_IE", rd, v);
    assert (lat > ACK_LATENCY) else begin
      $display("dbg_ack was not delayed by ex_stall");
      report_failure();
    end

    // Stall pass-through and flush on release
    stall_release(32'(rand_word(32)) | 32'd1);
    stall_release(32'd0);
    stall_release(32'h0001_0000);

    // Let the comparing process catch up
    drain = 0;
    while (name_q.size() > 0) begin
      if (drain >= 10) begin
        $display("Comparing process did not drain its queue");
        report_failure();
      end
      @(negedge clk);
      drain++;
    end
    $display("%0d checks done", chk_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
